// File: eeprom_bit_engine.sv
`timescale 1ns/1ps
module eeprom_bit_engine
#(
    parameter int CLK_DIV = 2
)
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_go,
    input  eeprom_pkg::bus_op_e op,
    input  logic [7:0]          op_byte,
    input  logic                sda_in,
    output logic                op_done,
    output logic [7:0]          op_rbyte,
    output logic                op_ack_bad,
    output logic                scl,
    output logic                sda_low
);
    localparam int            QW     = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    logic                active;
    eeprom_pkg::bus_op_e cur_op;
    logic [QW-1:0]       qcnt;    // CLK cycles within a quarter
    logic [5:0]          quarter; // quarter index within the op
    logic [5:0]          last_q;
    logic [5:0]          next_q;
    logic [7:0]          wbyte;
    logic                tick;
    logic                sample;
    logic [3:0]          bit_no;

    // {scl, sda_low} for quarter q of operation o
    function automatic logic [1:0] bus_level(input eeprom_pkg::bus_op_e o,
                                             input logic [5:0] q,
                                             input logic [7:0] b);
        logic [1:0] sub;
        logic [3:0] n;
        logic       c;
        logic       low;
        sub = q[1:0];
        n   = q[5:2];
        c   = (sub == 2'd1) || (sub == 2'd2); // high in the middle two quarters
        low = 1'b0;
        case (o)
            eeprom_pkg::OP_START:
                low = sub[1]; // falls while scl high
            eeprom_pkg::OP_STOP:
            begin
                c   = (sub != 2'd0);
                low = !sub[1]; // rises while scl high
            end
            eeprom_pkg::OP_WRITE:
                low = (n < 4'd8) && !b[~n[2:0]]; // msb first, ninth bit released
            default:
                low = 1'b0; // read bits and master nack left high
        endcase
        return {c, low};
    endfunction

    assign tick   = active && (qcnt == Q_LAST);
    assign bit_no = quarter[5:2];
    assign sample = tick && (quarter[1:0] == 2'd1); // middle of scl high
    assign next_q = quarter + 6'd1;
    assign last_q = (cur_op == eeprom_pkg::OP_WRITE || cur_op == eeprom_pkg::OP_READ) ?
                    6'd35 : 6'd3;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active     <= 1'b0;
            cur_op     <= eeprom_pkg::OP_STOP;
            qcnt       <= '0;
            quarter    <= '0;
            op_done    <= 1'b0;
            op_ack_bad <= 1'b0;
            scl        <= 1'b1;
            sda_low    <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (op_go)
            begin
                active           <= 1'b1;
                cur_op           <= op;
                qcnt             <= '0;
                quarter          <= '0;
                {scl, sda_low}   <= bus_level(op, 6'd0, op_byte);
                if (op == eeprom_pkg::OP_WRITE)
                    op_ack_bad <= 1'b0;
            end
            else if (active)
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    if (quarter == last_q)
                    begin
                        active  <= 1'b0; // wires hold their last level
                        op_done <= 1'b1;
                    end
                    else
                    begin
                        quarter        <= next_q;
                        {scl, sda_low} <= bus_level(cur_op, next_q, wbyte);
                    end
                end
                if (sample && bit_no == 4'd8 && cur_op == eeprom_pkg::OP_WRITE)
                    op_ack_bad <= sda_in; // memory acknowledge
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_go)
            wbyte <= op_byte;
        if (sample && bit_no < 4'd8 && cur_op == eeprom_pkg::OP_READ)
            op_rbyte <= {op_rbyte[6:0], sda_in};
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_low) && !(cur_op inside {eeprom_pkg::OP_START, eeprom_pkg::OP_STOP})
        |-> !scl && !$past(scl));

endmodule

// File: eeprom_ctrl_top.sv
`timescale 1ns/1ps
module eeprom_ctrl_top
#(
    parameter int CLK_DIV = 2
)
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          sda_in,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic [7:0]                    rdata,
    output logic                          scl,
    output logic                          sda_low
);
    logic                          req;
    logic                          req_rd;
    logic [eeprom_pkg::ADDR_W-1:0] req_addr;
    logic [7:0]                    req_wdata;
    logic                          done;
    logic                          done_nack;
    logic [7:0]                    done_rdata;
    logic                          op_go;
    eeprom_pkg::bus_op_e           op;
    logic [7:0]                    op_byte;
    logic                          op_done;
    logic [7:0]                    op_rbyte;
    logic                          op_ack_bad;

    eeprom_req_latch u_latch
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .done       (done),
        .done_nack  (done_nack),
        .done_rdata (done_rdata),
        .req        (req),
        .req_rd     (req_rd),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .busy       (busy),
        .ack        (ack),
        .nack       (nack),
        .rdata      (rdata)
    );

    eeprom_frame_seq u_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .req_rd     (req_rd),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .op_done    (op_done),
        .op_rbyte   (op_rbyte),
        .op_ack_bad (op_ack_bad),
        .op_go      (op_go),
        .op         (op),
        .op_byte    (op_byte),
        .done       (done),
        .done_nack  (done_nack),
        .done_rdata (done_rdata)
    );

    // scl period is 4 x CLK_DIV cycles
    eeprom_bit_engine #(.CLK_DIV(CLK_DIV)) u_bits
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .op_go      (op_go),
        .op         (op),
        .op_byte    (op_byte),
        .sda_in     (sda_in),
        .op_done    (op_done),
        .op_rbyte   (op_rbyte),
        .op_ack_bad (op_ack_bad),
        .scl        (scl),
        .sda_low    (sda_low)
    );

endmodule

// File: eeprom_frame_seq.sv
`timescale 1ns/1ps
module eeprom_frame_seq
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req,
    input  logic                          req_rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [7:0]                    req_wdata,
    input  logic                          op_done,
    input  logic [7:0]                    op_rbyte,
    input  logic                          op_ack_bad,
    output logic                          op_go,
    output eeprom_pkg::bus_op_e           op,
    output logic [7:0]                    op_byte,
    output logic                          done,
    output logic                          done_nack,
    output logic [7:0]                    done_rdata
);
    // state holds the operation in flight
    localparam logic [3:0] IDLE    = 4'd0;
    localparam logic [3:0] START   = 4'd1;
    localparam logic [3:0] CTRL_W  = 4'd2;
    localparam logic [3:0] ADDR    = 4'd3;
    localparam logic [3:0] DATA_W  = 4'd4;
    localparam logic [3:0] RESTART = 4'd5;
    localparam logic [3:0] CTRL_R  = 4'd6;
    localparam logic [3:0] DATA_R  = 4'd7;
    localparam logic [3:0] STOP    = 4'd8;
    localparam logic [3:0] DONE    = 4'd9;

    logic [3:0]                    state;
    logic                          rd_q;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [7:0]                    wdata_q;
    logic                          op_pending;
    eeprom_pkg::ctrl_byte_u        ctrl;

    always_comb
    begin
        ctrl.f.dev_code = eeprom_pkg::DEV_CODE;
        ctrl.f.page     = addr_q[eeprom_pkg::ADDR_W-1 -: 3];
        // read control byte follows the repeated start
        ctrl.f.rw       = (state == RESTART) ? eeprom_pkg::RW_READ : eeprom_pkg::RW_WRITE;
    end

    always_ff @(posedge CLK)
    begin
        if (req && state == IDLE)
        begin
            rd_q    <= req_rd;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            op_go     <= 1'b0;
            op        <= eeprom_pkg::OP_STOP;
            done      <= 1'b0;
            done_nack <= 1'b0;
        end
        else
        begin
            op_go <= 1'b0;
            done  <= 1'b0;
            case (state)
                IDLE:
                    if (req)
                    begin
                        op_go     <= 1'b1;
                        op        <= eeprom_pkg::OP_START;
                        done_nack <= 1'b0;
                        state     <= START;
                    end
                START, RESTART:
                    if (op_done)
                    begin
                        op_go   <= 1'b1;
                        op      <= eeprom_pkg::OP_WRITE;
                        op_byte <= ctrl.raw;
                        state   <= (state == START) ? CTRL_W : CTRL_R;
                    end
                CTRL_W, ADDR, CTRL_R:
                    if (op_done)
                    begin
                        op_go <= 1'b1;
                        if (op_ack_bad)
                        begin
                            op        <= eeprom_pkg::OP_STOP; // give up, close the frame
                            done_nack <= 1'b1;
                            state     <= STOP;
                        end
                        else if (state == CTRL_W)
                        begin
                            op      <= eeprom_pkg::OP_WRITE;
                            op_byte <= addr_q[7:0];
                            state   <= ADDR;
                        end
                        else if (state == CTRL_R)
                        begin
                            op    <= eeprom_pkg::OP_READ;
                            state <= DATA_R;
                        end
                        else if (rd_q)
                        begin
                            op    <= eeprom_pkg::OP_START;
                            state <= RESTART;
                        end
                        else
                        begin
                            op      <= eeprom_pkg::OP_WRITE;
                            op_byte <= wdata_q;
                            state   <= DATA_W;
                        end
                    end
                DATA_W, DATA_R:
                    if (op_done)
                    begin
                        op_go <= 1'b1;
                        op    <= eeprom_pkg::OP_STOP;
                        if (state == DATA_W)
                            done_nack <= op_ack_bad;
                        else
                            done_rdata <= op_rbyte;
                        state <= STOP;
                    end
                STOP:
                    if (op_done)
                    begin
                        done  <= 1'b1;
                        state <= DONE;
                    end
                default:
                    state <= IDLE; // DONE lands here too
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            op_pending <= 1'b0;
        else if (op_go)
            op_pending <= 1'b1;
        else if (op_done)
            op_pending <= 1'b0;
    end

    // one operation at a time, issued only right after req or op_done
    a_op_go: assert property (@(posedge CLK) disable iff (RESET)
        op_go |-> ($past(req) || $past(op_done)) && !op_pending);

endmodule

// File: eeprom_pkg.sv
package eeprom_pkg;

    // 2K x 8 part, three page bits above the byte address
    localparam int ADDR_W = 11;

    // upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // rw field of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // one operation on the two wires, sequencer to bit engine
    typedef enum logic [1:0]
    {
        OP_START = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_STOP  = 2'd3
    } bus_op_e;

    // control byte, built by fields and shifted out as a raw byte
    typedef union packed
    {
        logic [7:0] raw;
        struct packed
        {
            logic [3:0] dev_code;
            logic [2:0] page;
            logic       rw;
        } f;
    } ctrl_byte_u;

endpackage

// File: eeprom_req_latch.sv
`timescale 1ns/1ps
module eeprom_req_latch
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          done,
    input  logic                          done_nack,
    input  logic [7:0]                    done_rdata,
    output logic                          req,
    output logic                          req_rd,
    output logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    output logic [7:0]                    req_wdata,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic [7:0]                    rdata
);
    logic accept;

    assign accept = !busy && (wr || rd); // strobes ignored while busy

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req  <= 1'b0;
            busy <= 1'b0;
            ack  <= 1'b0;
        end
        else
        begin
            req <= accept;
            ack <= done;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0; // drops on the same edge ack rises
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_rd    <= !wr; // wr wins
            req_addr  <= addr;
            req_wdata <= wdata;
        end
        if (done)
        begin
            nack  <= done_nack;
            rdata <= done_rdata;
        end
    end

    // a result comes back only for a request in flight
    a_done_busy: assert property (@(posedge CLK) disable iff (RESET) done |-> busy && !req);
    a_ack_busy: assert property (@(posedge CLK) disable iff (RESET) !(ack && busy));

endmodule

// File: filelist.f
eeprom_pkg.sv
eeprom_req_latch.sv
eeprom_frame_seq.sv
eeprom_bit_engine.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the EEPROM controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_eeprom_ctrl -o tb_eeprom_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_eeprom_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
    echo "simulation ended without a pass line"
    exit 1
fi
exit 0

// File: tb_eeprom_ctrl.sv
`timescale 1ns/1ps
module tb_eeprom_ctrl;
    localparam int CLK_DIV      = 2;
    localparam int ACK_TIMEOUT  = 2000;
    localparam int QUIET_CYCLES = 400; // longer than any frame

    typedef struct packed
    {
        logic                          is_rd;
        logic [eeprom_pkg::ADDR_W-1:0] addr;
        logic [7:0]                    wdata;
        logic                          respond;
        logic                          extra;     // second strobe while busy
        logic                          exp_nack;
        logic [7:0]                    exp_rdata;
    } row_t;

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [7:0]                    wdata;
    logic                          busy;
    logic                          ack;
    logic                          nack;
    logic [7:0]                    rdata;
    logic                          scl;
    logic                          sda_low;
    logic                          sda_line;
    logic                          model_pull;
    logic                          respond;
    int                            proto_errors;
    int                            errors;
    int                            seed;
    row_t                          rows[$];
    logic [7:0]                    shadow [0:2047];

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) dut0
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda_line),
        .busy    (busy),
        .ack     (ack),
        .nack    (nack),
        .rdata   (rdata),
        .scl     (scl),
        .sda_low (sda_low)
    );

    tb_eeprom_model u_model
    (
        .scl          (scl),
        .sda          (sda_line),
        .respond      (respond),
        .sda_pull     (model_pull),
        .proto_errors (proto_errors)
    );

    assign sda_line = !(sda_low || model_pull); // wired-and with pull-up

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [7:0] power_up(input logic [10:0] a);
        return a[7:0] ^ 8'(a[10:8] * 8'd37);
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // expected values follow the shadow as rows are queued
    task automatic add_row(input logic is_rd, input logic [10:0] a, input logic [7:0] d,
                           input logic resp, input logic extra);
        row_t r;
        r.is_rd     = is_rd;
        r.addr      = a;
        r.wdata     = d;
        r.respond   = resp;
        r.extra     = extra;
        r.exp_nack  = !resp;
        r.exp_rdata = shadow[a];
        if (!is_rd && resp)
            shadow[a] = d;
        rows.push_back(r);
    endtask

    task automatic run_row(input row_t r);
        int cyc;
        int acks;
        cyc  = 0;
        acks = 0;
        repeat (4) @(posedge CLK);
        #2;
        respond = r.respond;
        wr      = !r.is_rd;
        rd      = r.is_rd;
        addr    = r.addr;
        wdata   = r.wdata;
        while (acks == 0 && cyc < ACK_TIMEOUT)
        begin
            @(posedge CLK);
            #2;
            cyc++;
            wr = 1'b0;
            rd = 1'b0;
            if (r.extra && cyc == 3)
            begin
                wr    = 1'b1; // must be dropped, busy is high
                addr  = r.addr ^ 11'h0ff;
                wdata = ~r.wdata;
            end
            if (ack)
                acks++;
        end
        if (acks == 0)
        begin
            $display("timeout: no ack within %0d cycles for address %h", ACK_TIMEOUT, r.addr);
            errors++;
        end
        else
        begin
            check_flag(nack, r.exp_nack, "nack");
            check_flag(busy, 1'b0, "busy at ack");
            if (r.is_rd && r.respond)
                check_byte(rdata, r.exp_rdata, "rdata");
            if (r.extra)
            begin
                cyc = 0;
                while (cyc < QUIET_CYCLES)
                begin
                    @(posedge CLK);
                    #2;
                    cyc++;
                    if (ack)
                        acks++;
                end
                if (acks != 1)
                begin
                    $display("FAIL %0t: %0d acks for a strobe pair", $time, acks);
                    errors++;
                end
            end
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [10:0] a;
        errors  = 0;
        seed    = 14798;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        respond = 1'b1;
        for (logic [11:0] i = 12'd0; i < 12'd2048; i++)
            shadow[i[10:0]] = power_up(i[10:0]);

        add_row(1'b0, 11'h123, 8'ha5, 1'b1, 1'b0);
        add_row(1'b0, 11'h223, 8'h5a, 1'b1, 1'b0); // same low byte, other page
        add_row(1'b1, 11'h123, 8'h00, 1'b1, 1'b0);
        add_row(1'b1, 11'h223, 8'h00, 1'b1, 1'b0);
        add_row(1'b1, 11'h023, 8'h00, 1'b1, 1'b0);
        add_row(1'b0, 11'h456, 8'h3c, 1'b0, 1'b0); // memory silent
        add_row(1'b1, 11'h456, 8'h00, 1'b0, 1'b0);
        add_row(1'b1, 11'h456, 8'h00, 1'b1, 1'b0);
        add_row(1'b0, 11'h777, 8'hc3, 1'b1, 1'b1);
        add_row(1'b1, 11'h777, 8'h00, 1'b1, 1'b0);
        add_row(1'b1, 11'h788, 8'h00, 1'b1, 1'b0); // target of the dropped strobe
        for (int k = 0; k < 3; k++)
        begin
            rnd = $random(seed);
            a   = rnd[10:0];
            add_row(1'b1, a, 8'h00, 1'b1, 1'b0);
            add_row(1'b0, a, rnd[23:16], 1'b1, 1'b0);
            add_row(1'b1, a, 8'h00, 1'b1, 1'b0);
        end

        repeat (16) @(posedge CLK);
        #2;
        RESET = 1'b0;
        check_flag(scl, 1'b1, "scl after reset");
        check_flag(sda_low, 1'b0, "sda_low after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(ack, 1'b0, "ack after reset");

        foreach (rows[n])
            run_row(rows[n]);

        repeat (10) @(posedge CLK);
        $display("errors: %0d  protocol errors: %0d", errors, proto_errors);
        if (errors == 0 && proto_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb_eeprom_model.sv
`timescale 1ns/1ps
module tb_eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic respond,
    output logic sda_pull,
    output int   proto_errors
);
    localparam int P_IDLE  = 0;
    localparam int P_CTRL  = 1;
    localparam int P_ADDR  = 2;
    localparam int P_WDATA = 3;
    localparam int P_TX    = 4;
    localparam int P_DONE  = 5;

    logic [7:0]             mem [0:2047];
    logic [2:0]             page;
    logic [7:0]             lo;       // byte address within the page
    logic [7:0]             shreg;
    logic [7:0]             txbyte;
    int                     nbits;    // scl rises seen in this byte
    int                     phase;
    int                     next_phase;
    logic                   scl_q;
    int                     err_cnt;
    eeprom_pkg::ctrl_byte_u cb;

    initial
    begin
        // power-up contents, low byte xor page times 37
        for (logic [11:0] a = 12'd0; a < 12'd2048; a++)
            mem[a[10:0]] = a[7:0] ^ 8'(a[10:8] * 8'd37);
        sda_pull   = 1'b0;
        phase      = P_IDLE;
        next_phase = P_IDLE;
        nbits      = 0;
        err_cnt    = 0;
        scl_q      = 1'b1;
    end

    assign proto_errors = err_cnt;

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl !== scl_q)
        begin
            if (scl === 1'b1 && phase != P_IDLE && phase != P_DONE)
            begin
                if (nbits < 8 && phase != P_TX)
                    shreg = {shreg[6:0], sda};
                nbits = nbits + 1;
            end
            else if (scl === 1'b0 && phase != P_IDLE && phase != P_DONE)
            begin
                if (nbits == 8 && phase == P_TX)
                    sda_pull = 1'b0; // let the master answer
                else if (nbits == 8)
                begin
                    cb.raw   = shreg;
                    sda_pull = respond;
                    case (phase)
                        P_CTRL:
                        begin
                            sda_pull   = respond && cb.f.dev_code == eeprom_pkg::DEV_CODE;
                            page       = cb.f.page;
                            txbyte     = mem[{cb.f.page, lo}];
                            next_phase = cb.f.rw ? P_TX : P_ADDR;
                        end
                        P_ADDR:
                        begin
                            lo         = shreg;
                            next_phase = P_WDATA;
                        end
                        default:
                        begin
                            if (respond)
                                mem[{page, lo}] = shreg;
                            next_phase = P_DONE;
                        end
                    endcase
                    if (!sda_pull)
                        next_phase = P_IDLE; // no ack, wait for the next frame
                end
                else if (nbits == 9)
                begin
                    nbits    = 0;
                    phase    = (phase == P_TX) ? P_DONE : next_phase; // no sequential reads
                    sda_pull = (phase == P_TX) && !txbyte[7]; // first read bit
                end
                else if (phase == P_TX && nbits > 0)
                begin
                    txbyte   = {txbyte[6:0], 1'b0};
                    sda_pull = !txbyte[7];
                end
            end
        end
        else if (scl === 1'b1)
        begin
            // start or stop, legal only where the first bit of a byte would be
            if (nbits > 1)
                err_cnt = err_cnt + 1;
            nbits    = 0;
            sda_pull = 1'b0;
            phase    = (sda === 1'b0) ? P_CTRL : P_IDLE;
        end
        scl_q = scl;
    end

endmodule
